// File: logic/pcie_cfg_pkg.sv
`default_nettype none

package pcie_cfg_pkg;

	//////////////////////////////
	// Register offsets

	// Type 0 header, one word each
	localparam logic [7:0] REG_DEVICE_VENDOR  = 8'h00;
	localparam logic [7:0] REG_STATUS_COMMAND = 8'h04;
	localparam logic [7:0] REG_CLASS_REV      = 8'h08;
	localparam logic [7:0] REG_TYPE_INFO      = 8'h0c;
	localparam logic [7:0] REG_BAR0           = 8'h10;
	localparam logic [7:0] REG_BAR1           = 8'h14;
	localparam logic [7:0] REG_BAR2           = 8'h18;
	localparam logic [7:0] REG_BAR3           = 8'h1c;
	localparam logic [7:0] REG_BAR4           = 8'h20;
	localparam logic [7:0] REG_BAR5           = 8'h24;
	localparam logic [7:0] REG_CAPS_PTR       = 8'h34;

	// PCIe capability block at 0x40
	localparam logic [7:0] REG_PCIE_CAP_HDR    = 8'h40;
	localparam logic [7:0] REG_PCIE_DEV_CAPS   = 8'h44;
	localparam logic [7:0] REG_PCIE_DEV_CTL    = 8'h48;
	localparam logic [7:0] REG_PCIE_LINK_CAPS  = 8'h4c;
	localparam logic [7:0] REG_PCIE_LINK_CTL   = 8'h50;
	localparam logic [7:0] REG_PCIE_LINK_CAPS2 = 8'h6c;

	//////////////////////////////
	// Identity

	localparam logic [15:0] DEVICE_ID   = 16'h7a21;
	localparam logic [15:0] VENDOR_ID   = 16'h5a17;
	// Memory controller, RAM
	localparam logic [7:0]  BASE_CLASS  = 8'h05;
	localparam logic [7:0]  SUB_CLASS   = 8'h00;
	localparam logic [7:0]  PROG_IFACE  = 8'h00;
	localparam logic [7:0]  REVISION_ID = 8'h01;

	//////////////////////////////
	// Fixed capability words

	// Cap ID 0x10, no next pointer, version 2, endpoint
	localparam logic [31:0] PCIE_CAP_HDR_VAL = 32'h0002_0010;
	// 256 byte max payload, no FLR
	localparam logic [31:0] DEV_CAPS_VAL     = 32'h0000_0001;
	// 256 byte payload and read request
	localparam logic [31:0] DEV_CTL_VAL      = 32'h0000_1020;
	// 2.5G only, x1 only
	localparam logic [31:0] LINK_CAPS_VAL    = 32'h0000_0011;
	// Supported speeds vector, 2.5G
	localparam logic [31:0] LINK_CAPS2_VAL   = 32'h0000_0002;
	localparam logic [31:0] CAPS_PTR_VAL     = 32'h0000_0040;

	// Returned for any aligned address with no register
	localparam logic [31:0] UNMAPPED_VAL = 32'hffff_ffff;

	//////////////////////////////
	// Base address registers

	localparam int NUM_BARS = 6;

	// BAR0 64 KiB, BAR1 4 KiB, the rest not implemented
	localparam logic [31:0] BAR_SIZE_MASK [NUM_BARS] = '{
		32'hffff_0000,
		32'hffff_f000,
		32'h0000_0000,
		32'h0000_0000,
		32'h0000_0000,
		32'h0000_0000
	};

	localparam logic BAR_PREFETCH [NUM_BARS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

	// One BAR word, raw or split into its type fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [27:0] base_addr;
			logic        prefetchable;
			logic [1:0]  mem_type;
			logic        io_space;
		} fields;
	} bar_word_u;

	//////////////////////////////
	// Link and bus control

	// Cycles of stable link before DLL up is reported
	localparam logic [15:0] LINK_SETTLE_CYCLES = 16'd16;

	// APB completer states
	localparam logic [1:0] FSM_IDLE = 2'd0;
	localparam logic [1:0] FSM_REQ  = 2'd1;
	localparam logic [1:0] FSM_RESP = 2'd2;

endpackage

`default_nettype wire

// File: logic/cfg_access_if.sv
`timescale 1ns/1ps
`default_nettype none

// Internal request path from the APB FSM into the register space
interface cfg_access_if;

	// Request, held until accepted
	logic        valid;
	logic        write;
	logic [7:0]  addr;
	logic [31:0] wdata;

	// Response, only meaningful in the transfer cycle
	logic        ready;
	logic [31:0] rdata;
	logic        err;

	// APB side
	modport requester (
		output valid, write, addr, wdata,
		input  ready, rdata, err
	);

	// Register space side
	modport target (
		input  valid, write, addr, wdata,
		output ready, rdata, err
	);

endinterface

`default_nettype wire

// File: logic/apb_completer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module apb_completer_fsm import pcie_cfg_pkg::*; (
	input  wire               apb,
	input  wire               rst_n,
	input  wire               psel,
	input  wire               penable,
	input  wire               pwrite,
	input  wire [7:0]         paddr,
	input  wire [31:0]        pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	cfg_access_if.requester   req
);

	//////////////////////////////
	// Phase tracking

	logic [1:0]  state;
	logic        setup;
	logic        xfer;

	// Latched request fields
	logic        write_q;
	logic [7:0]  addr_q;
	logic [31:0] wdata_q;

	// Setup phase seen from idle
	assign setup = psel && !penable;
	assign xfer = req.valid && req.ready;

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			state <= FSM_IDLE;
		end else begin
			case (state)
				FSM_IDLE: if (setup) state <= FSM_REQ;
				// Wait here while the target holds off
				FSM_REQ: if (xfer) state <= FSM_RESP;
				FSM_RESP: state <= FSM_IDLE;
				default: state <= FSM_IDLE;
			endcase
		end
	end

	// Capture address and data at the end of setup
	always_ff @(posedge apb) begin
		if (state == FSM_IDLE && setup) begin
			write_q <= pwrite;
			addr_q  <= paddr;
			wdata_q <= pwdata;
		end
	end

	//////////////////////////////
	// Internal request

	assign req.valid = (state == FSM_REQ);
	assign req.write = write_q;
	assign req.addr  = addr_q;
	assign req.wdata = wdata_q;

	//////////////////////////////
	// Registered response

	// Completion lands in the second access cycle
	// Data and error are zero outside it
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			pready  <= 1'b0;
			prdata  <= '0;
			pslverr <= 1'b0;
		end else if (xfer) begin
			pready  <= 1'b1;
			prdata  <= req.rdata;
			pslverr <= req.err;
		end else begin
			pready  <= 1'b0;
			prdata  <= '0;
			pslverr <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/link_settle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module link_settle_timer import pcie_cfg_pkg::*; (
	input  wire  apb,
	input  wire  rst_n,
	input  wire  dl_link_up,
	output logic link_up_ok
);

	//////////////////////////////
	// Settle counter

	// Consecutive cycles with link up, saturates
	logic [15:0] stable_cnt;

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			stable_cnt <= '0;
			link_up_ok <= 1'b0;
		end else if (!dl_link_up) begin
			// Any drop restarts the window
			stable_cnt <= '0;
			link_up_ok <= 1'b0;
		end else begin
			if (stable_cnt != LINK_SETTLE_CYCLES)
				stable_cnt <= stable_cnt + 16'd1;
			// Edge that completes the full window
			if (stable_cnt >= LINK_SETTLE_CYCLES - 16'd1)
				link_up_ok <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/bar_bank.sv
`timescale 1ns/1ps
`default_nettype none

module bar_bank import pcie_cfg_pkg::*; (
	input  wire                          apb,
	input  wire                          rst_n,
	input  wire                          bar_we,
	input  wire  [2:0]                   bar_idx,
	input  wire  [31:0]                  bar_wdata,
	output logic [NUM_BARS-1:0][31:0]    bar_rdata
);

	//////////////////////////////
	// One slice per BAR

	for (genvar i = 0; i < NUM_BARS; i++) begin : g_bar

		// Stored BAR value
		logic [31:0] bar_q;
		// Value after aperture masking
		bar_word_u   wr_word;

		always_comb begin
			// Only the base bits inside the aperture are kept
			wr_word.raw = bar_wdata & BAR_SIZE_MASK[i];
			// Hardwired type for implemented BARs
			if (BAR_SIZE_MASK[i] != 32'h0) begin
				wr_word.fields.prefetchable = BAR_PREFETCH[i];
				// 32 bit memory space
				wr_word.fields.mem_type = 2'b00;
				wr_word.fields.io_space = 1'b0;
			end
		end

		// All ones written by the host reads back as the size mask
		always_ff @(posedge apb or negedge rst_n) begin
			if (!rst_n)
				bar_q <= '0;
			else if (bar_we && bar_idx == 3'(i))
				bar_q <= wr_word.raw;
		end

		assign bar_rdata[i] = bar_q;

	end

endmodule

`default_nettype wire

// File: logic/pcie_cfg_space.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_cfg_space import pcie_cfg_pkg::*; (
	input  wire            apb,
	input  wire            rst_n,
	input  wire            link_up_ok,
	cfg_access_if.target   tgt
);

	logic                       misaligned;
	logic [31:0]                status_command;
	logic [31:0]                link_ctl_status;
	logic [31:0]                word;
	logic                       bar_hit;
	logic                       bar_we;
	logic [2:0]                 bar_idx;
	logic [NUM_BARS-1:0][31:0]  bar_rdata;

	//////////////////////////////
	// Handshake

	// Never stalls
	assign tgt.ready = tgt.valid;
	// Byte offsets must be word aligned
	assign misaligned = (tgt.addr[1:0] != 2'b00);
	assign tgt.err = misaligned;

	//////////////////////////////
	// Built words

	// Status has only the capability list bit
	assign status_command = {11'h000, 1'b1, 4'h0, 16'h0000};

	// Link status upper half, control lower half all zero
	assign link_ctl_status = {
		2'b00,
		// DLL active after settle
		link_up_ok,
		3'b000,
		// Negotiated width x1
		6'h01,
		// Current speed 2.5G
		4'h1,
		16'h0000
	};

	//////////////////////////////
	// Read mux

	always_comb begin
		case (tgt.addr)
			REG_DEVICE_VENDOR:   word = {DEVICE_ID, VENDOR_ID};
			REG_STATUS_COMMAND:  word = status_command;
			REG_CLASS_REV:       word = {BASE_CLASS, SUB_CLASS, PROG_IFACE, REVISION_ID};
			// Header type 0, single function
			REG_TYPE_INFO:       word = 32'h0000_0000;
			REG_BAR0:            word = bar_rdata[0];
			REG_BAR1:            word = bar_rdata[1];
			REG_BAR2:            word = bar_rdata[2];
			REG_BAR3:            word = bar_rdata[3];
			REG_BAR4:            word = bar_rdata[4];
			REG_BAR5:            word = bar_rdata[5];
			REG_CAPS_PTR:        word = CAPS_PTR_VAL;
			REG_PCIE_CAP_HDR:    word = PCIE_CAP_HDR_VAL;
			REG_PCIE_DEV_CAPS:   word = DEV_CAPS_VAL;
			REG_PCIE_DEV_CTL:    word = DEV_CTL_VAL;
			REG_PCIE_LINK_CAPS:  word = LINK_CAPS_VAL;
			REG_PCIE_LINK_CTL:   word = link_ctl_status;
			REG_PCIE_LINK_CAPS2: word = LINK_CAPS2_VAL;
			default:             word = UNMAPPED_VAL;
		endcase
	end

	// Zero on error and on writes
	assign tgt.rdata = (misaligned || tgt.write) ? 32'h0 : word;

	//////////////////////////////
	// BAR write steering

	// Misaligned offsets never match a BAR
	always_comb begin
		bar_hit = 1'b1;
		bar_idx = 3'd0;
		case (tgt.addr)
			REG_BAR0: bar_idx = 3'd0;
			REG_BAR1: bar_idx = 3'd1;
			REG_BAR2: bar_idx = 3'd2;
			REG_BAR3: bar_idx = 3'd3;
			REG_BAR4: bar_idx = 3'd4;
			REG_BAR5: bar_idx = 3'd5;
			default:  bar_hit = 1'b0;
		endcase
	end

	// Other writes complete and are dropped
	assign bar_we = tgt.valid && tgt.ready && tgt.write && bar_hit;

	bar_bank u_bar_bank (
		.apb       (apb),
		.rst_n     (rst_n),
		.bar_we    (bar_we),
		.bar_idx   (bar_idx),
		.bar_wdata (tgt.wdata),
		.bar_rdata (bar_rdata)
	);

endmodule

`default_nettype wire

// File: logic/pcie_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_cfg_top (
	input  wire         apb,
	input  wire         rst_n,

	// APB completer port
	input  wire         psel,
	input  wire         penable,
	input  wire         pwrite,
	input  wire  [7:0]  paddr,
	input  wire  [31:0] pwdata,
	output wire  [31:0] prdata,
	output wire         pready,
	output wire         pslverr,

	// Raw link state from the PHY side
	input  wire         dl_link_up
);

	//////////////////////////////
	// Internal links

	cfg_access_if u_cfg_if ();

	// Filtered link up
	wire link_up_ok;

	//////////////////////////////
	// Instances

	apb_completer_fsm u_apb_fsm (
		.apb     (apb),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.req     (u_cfg_if.requester)
	);

	link_settle_timer u_link_timer (
		.apb        (apb),
		.rst_n      (rst_n),
		.dl_link_up (dl_link_up),
		.link_up_ok (link_up_ok)
	);

	pcie_cfg_space u_cfg_space (
		.apb        (apb),
		.rst_n      (rst_n),
		.link_up_ok (link_up_ok),
		.tgt        (u_cfg_if.target)
	);

endmodule

`default_nettype wire

// File: verif/pcie_cfg_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_cfg_chk (
	input wire        apb,
	input wire        rst_n,
	input wire        psel,
	input wire        penable,
	input wire        pready,
	input wire        pslverr,
	input wire [31:0] prdata
);

	//////////////////////////////
	// APB completer rules

	// One completion cycle per transfer
	a_pready_single: assert property (@(posedge apb) disable iff (!rst_n)
		pready |=> !pready)
		else $error("pready stayed high for more than one cycle");

	// Error only alongside a completion
	a_slverr_with_ready: assert property (@(posedge apb) disable iff (!rst_n)
		pslverr |-> pready)
		else $error("pslverr raised without pready");

	// Completion only inside an access phase
	a_ready_in_access: assert property (@(posedge apb) disable iff (!rst_n)
		pready |-> (psel && penable))
		else $error("pready raised outside an access phase");

	// Idle bus reads zero
	a_idle_rdata_zero: assert property (@(posedge apb) disable iff (!rst_n)
		!psel |-> (prdata == 32'h0))
		else $error("prdata not zero while psel is low");

endmodule

`default_nettype wire

// File: verif/pcie_cfg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_cfg_tb import pcie_cfg_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int BUS_TIMEOUT = 20;
	localparam int LINK_POLLS = 20;
	// DLL link active, bit 13 of link status
	localparam int DLL_ACTIVE_BIT = 29;

	logic        apb;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic        dl_link_up;
	wire  [31:0] prdata;
	wire         pready;
	wire         pslverr;

	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	// Last transfer, wait cycles and completion cycle
	int last_waits;
	int last_done_cycle;

	pcie_cfg_top u_dut (
		.apb        (apb),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.dl_link_up (dl_link_up)
	);

	bind pcie_cfg_top pcie_cfg_chk u_chk (
		.apb     (apb),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pready  (pready),
		.pslverr (pslverr),
		.prdata  (prdata)
	);

	initial begin
		apb = 1'b0;
		forever #4 apb = ~apb;
	end

	always @(posedge apb) cycle_cnt <= cycle_cnt + 1;

	//////////////////////////////
	// Helpers

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: t=%0t %s: got 0x%08h, expected 0x%08h",
				$time, what, actual, expected);
		end
	endtask

	// Setup then access, entered and left 1 ns after a rising edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] data, output logic err);
		int waits;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge apb);
		#1;
		penable = 1'b1;
		waits = 0;
		while (!pready && waits < BUS_TIMEOUT) begin
			@(posedge apb);
			#1;
			waits++;
		end
		if (!pready) begin
			$display("APB bus hung: no pready within %0d cycles at address 0x%02h",
				BUS_TIMEOUT, addr);
			$display("TESTS FAILED");
			$finish;
		end else begin
			data = prdata;
			err = pslverr;
			last_waits = waits;
			last_done_cycle = cycle_cnt;
			@(posedge apb);
			#1;
			psel = 1'b0;
			penable = 1'b0;
			pwrite = 1'b0;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused_data;
		logic        err;
		apb_xfer(1'b1, addr, wdata, unused_data, err);
		check_value($sformatf("pslverr on write 0x%02h", addr), 32'(err), 32'h0);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		apb_xfer(1'b0, addr, 32'h0, data, err);
	endtask

	// Read, expect a value and no error
	task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] data;
		logic        err;
		apb_read(addr, data, err);
		check_value($sformatf("read 0x%02h", addr), data, expected);
		check_value($sformatf("pslverr on read 0x%02h", addr), 32'(err), 32'h0);
	endtask

	function automatic logic [7:0] bar_addr(input int idx);
		return REG_BAR0 + 8'(idx * 4);
	endfunction

	// Writable base bits from the aperture size, none for unimplemented BARs
	function automatic logic [31:0] aperture_mask(input int idx);
		logic [31:0] mask;
		case (idx)
			// 64 KiB
			0: mask = ~(32'd65536 - 32'd1);
			// 4 KiB
			1: mask = ~(32'd4096 - 32'd1);
			default: mask = 32'h0;
		endcase
		return mask;
	endfunction

	// Only BAR1 is prefetchable
	function automatic logic bar_prefetchable(input int idx);
		return idx == 1;
	endfunction

	// Aperture bits kept, 32 bit memory type, prefetch per BAR
	function automatic logic [31:0] expected_bar(input int idx, input logic [31:0] wdata);
		logic [31:0] val;
		val = wdata & aperture_mask(idx) & 32'hffff_fff0;
		if (aperture_mask(idx) != 32'h0)
			val = val | {28'h0, bar_prefetchable(idx), 3'b000};
		return val;
	endfunction

	//////////////////////////////
	// Directed tests

	task automatic test_identity();
		read_expect(REG_DEVICE_VENDOR, {DEVICE_ID, VENDOR_ID});
		// Capability list, status bit 4
		read_expect(REG_STATUS_COMMAND, 32'h0010_0000);
		read_expect(REG_CLASS_REV, {BASE_CLASS, SUB_CLASS, PROG_IFACE, REVISION_ID});
		// Header type 0, single function
		read_expect(REG_TYPE_INFO, 32'h0);
		read_expect(REG_CAPS_PTR, CAPS_PTR_VAL);
		read_expect(REG_PCIE_CAP_HDR, PCIE_CAP_HDR_VAL);
		read_expect(REG_PCIE_DEV_CAPS, DEV_CAPS_VAL);
		read_expect(REG_PCIE_DEV_CTL, DEV_CTL_VAL);
		read_expect(REG_PCIE_LINK_CAPS, LINK_CAPS_VAL);
		read_expect(REG_PCIE_LINK_CAPS2, LINK_CAPS2_VAL);
	endtask

	task automatic test_unmapped();
		logic [31:0] data;
		logic        err;
		read_expect(8'h38, UNMAPPED_VAL);
		read_expect(8'h5c, UNMAPPED_VAL);
		read_expect(8'hfc, UNMAPPED_VAL);
		// Misaligned, zero data with error
		apb_read(8'h11, data, err);
		check_value("misaligned read data", data, 32'h0);
		check_value("misaligned read pslverr", 32'(err), 32'h1);
		// Read-only words ignore writes
		apb_write(REG_DEVICE_VENDOR, 32'hdead_beef);
		read_expect(REG_DEVICE_VENDOR, {DEVICE_ID, VENDOR_ID});
		apb_write(REG_PCIE_CAP_HDR, 32'h1234_5678);
		read_expect(REG_PCIE_CAP_HDR, PCIE_CAP_HDR_VAL);
	endtask

	task automatic test_bar_sizing();
		logic [31:0] data;
		logic        err;
		logic [31:0] mask;
		bar_word_u   rb;
		for (int i = 0; i < NUM_BARS; i++) begin
			apb_write(bar_addr(i), 32'hffff_ffff);
			apb_read(bar_addr(i), data, err);
			check_value($sformatf("BAR%0d size readback", i), data, expected_bar(i, '1));
			rb.raw = data;
			mask = aperture_mask(i);
			check_value($sformatf("BAR%0d base", i), 32'(rb.fields.base_addr),
				32'(mask[31:4]));
			check_value($sformatf("BAR%0d io space", i), 32'(rb.fields.io_space), 32'h0);
			check_value($sformatf("BAR%0d mem type", i), 32'(rb.fields.mem_type), 32'h0);
			// Unimplemented BARs read all zero
			check_value($sformatf("BAR%0d prefetch", i), 32'(rb.fields.prefetchable),
				32'(bar_prefetchable(i)));
		end
	endtask

	task automatic test_bar_program();
		logic [31:0] wd;
		logic [31:0] data;
		logic        err;
		repeat (4) begin
			for (int i = 0; i < 2; i++) begin
				wd = $urandom();
				apb_write(bar_addr(i), wd);
				apb_read(bar_addr(i), data, err);
				check_value($sformatf("BAR%0d after 0x%08h", i, wd), data, expected_bar(i, wd));
			end
		end
	endtask

	task automatic test_link_settle();
		logic [31:0] data;
		logic        err;
		int          rise;
		int          polls;
		logic        seen;
		dl_link_up = 1'b1;
		rise = cycle_cnt;
		polls = 0;
		seen = 1'b0;
		while (!seen && polls < LINK_POLLS) begin
			apb_read(REG_PCIE_LINK_CTL, data, err);
			polls++;
			// Too early for the settle window
			if (last_done_cycle - rise < int'(LINK_SETTLE_CYCLES))
				check_value("link up before settle time", 32'(data[DLL_ACTIVE_BIT]), 32'h0);
			seen = data[DLL_ACTIVE_BIT];
		end
		if (!seen) begin
			errors++;
			$display("Link-up bit never set after %0d status reads", polls);
		end
		dl_link_up = 1'b0;
		apb_read(REG_PCIE_LINK_CTL, data, err);
		check_value("link up after drop", 32'(data[DLL_ACTIVE_BIT]), 32'h0);
		// Short pulse, three reads span about nine cycles
		dl_link_up = 1'b1;
		repeat (3) begin
			apb_read(REG_PCIE_LINK_CTL, data, err);
			check_value("link up during short pulse", 32'(data[DLL_ACTIVE_BIT]), 32'h0);
		end
		dl_link_up = 1'b0;
		apb_read(REG_PCIE_LINK_CTL, data, err);
		check_value("link up after short pulse", 32'(data[DLL_ACTIVE_BIT]), 32'h0);
	endtask

	task automatic test_back_to_back();
		logic [31:0] wd;
		logic [31:0] data;
		logic        err;
		for (int i = 0; i < 2; i++) begin
			wd = $urandom();
			apb_write(bar_addr(i), wd);
			check_value("write wait states", 32'(last_waits), 32'h1);
			// Read starts right after the write
			apb_read(bar_addr(i), data, err);
			check_value("read wait states", 32'(last_waits), 32'h1);
			check_value($sformatf("BAR%0d back to back", i), data, expected_bar(i, wd));
		end
	endtask

	//////////////////////////////
	// Run

	initial begin
		void'($urandom(32'hfe2e));
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h0;
		pwdata = 32'h0;
		dl_link_up = 1'b0;
		repeat (RESET_CYCLES) @(posedge apb);
		#1;
		rst_n = 1'b1;
		check_value("pready after reset", 32'(pready), 32'h0);
		check_value("pslverr after reset", 32'(pslverr), 32'h0);
		@(posedge apb);
		#1;
		test_identity();
		test_unmapped();
		test_bar_sizing();
		test_bar_program();
		test_link_settle();
		test_back_to_back();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
logic/pcie_cfg_pkg.sv
logic/cfg_access_if.sv
logic/apb_completer_fsm.sv
logic/link_settle_timer.sv
logic/bar_bank.sv
logic/pcie_cfg_space.sv
logic/pcie_cfg_top.sv
verif/pcie_cfg_chk.sv
verif/pcie_cfg_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = pcie_cfg_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Status comes from the pass line in the simulator output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
